/* avionics_config.svh */
// Board-wide constants for the flight-control core.
// Include wherever a pulse limit, timeout or timebase default is needed.
`ifndef AVIONICS_CONFIG_SVH
`define AVIONICS_CONFIG_SVH

// Receiver and output pulse timing, in microseconds
`define AV_PULSE_MIN_US      1000
`define AV_FRAME_US          20000
`define AV_SERVO_STEP_US     4
`define AV_RADIO_TIMEOUT_US  25000

// Button must stay stable this many milliseconds
`define AV_DEBOUNCE_MS       2

// Arm gesture: throttle low, elevator high, held for AV_ARM_HOLD 10 Hz ticks
`define AV_ARM_THR_MAX       32
`define AV_ARM_ELEV_MIN      960
`define AV_ARM_HOLD          10

// System clock cycles per microsecond
`define AV_CLKS_PER_US       125

`endif

/* avionics_pkg.sv */
// Shared types for the flight-control core.
// Modules import this for channel values, servo commands and board states.
`default_nettype none

package avionics_pkg;

  // Decoded receiver channel, 0 at 1000 us up to 1023
  typedef logic [9:0] chan_val_t;

  // Servo command, one step per AV_SERVO_STEP_US
  typedef logic [7:0] servo_val_t;

  // Microsecond counts for pulses, gaps and frames
  typedef logic [15:0] us_count_t;

  typedef enum logic [1:0] {
    BOARD_IDLE     = 2'd0,
    BOARD_STARTUP  = 2'd1,
    BOARD_RUNNING  = 2'd2,
    BOARD_SHUTDOWN = 2'd3
  } board_state_t;

endpackage

`default_nettype wire

/* tick_if.sv */
// Timebase bundle shared by the capture, control and output blocks.
// tick_gen drives the source side; all consumers attach to the sink side.
`timescale 1ns/1ps
`default_nettype none

interface tick_if;
  // One-cycle pulses
  logic tick_us;
  logic tick_ms;
  logic tick_10hz;
  // Level toggled on every tick_10hz
  logic blink;

  modport source (
    output tick_us,
    output tick_ms,
    output tick_10hz,
    output blink
  );

  modport sink (
    input tick_us,
    input tick_ms,
    input tick_10hz,
    input blink
  );
endinterface

`default_nettype wire

/* tick_gen.sv */
// Timebase generator: microsecond, millisecond and 10 Hz ticks plus a blink level.
// Counters are held cleared while run is low.
`timescale 1ns/1ps
`default_nettype none
`include "avionics_config.svh"

module tick_gen #(
  parameter int CLKS_PER_US = `AV_CLKS_PER_US
) (
  input  logic  clk,
  input  logic  rst_n,
  input  logic  run,
  tick_if.source ticks
);
  localparam int DIV_W = (CLKS_PER_US > 1) ? $clog2(CLKS_PER_US) : 1;

  logic [DIV_W-1:0] div_cnt;
  logic [9:0]       us_cnt;
  logic [6:0]       ms_cnt;
  logic             us_end;
  logic             ms_end;
  logic             hz_end;
  logic             tick_us_q;
  logic             tick_ms_q;
  logic             tick_10hz_q;
  logic             blink_q;

  assign us_end = (div_cnt == DIV_W'(CLKS_PER_US - 1));
  assign ms_end = us_end && (us_cnt == 10'd999);
  assign hz_end = ms_end && (ms_cnt == 7'd99);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      div_cnt     <= '0;
      us_cnt      <= '0;
      ms_cnt      <= '0;
      tick_us_q   <= 1'b0;
      tick_ms_q   <= 1'b0;
      tick_10hz_q <= 1'b0;
      blink_q     <= 1'b0;
    end else if (!run) begin
      div_cnt     <= '0;
      us_cnt      <= '0;
      ms_cnt      <= '0;
      tick_us_q   <= 1'b0;
      tick_ms_q   <= 1'b0;
      tick_10hz_q <= 1'b0;
      blink_q     <= 1'b0;
    end else begin
      div_cnt <= us_end ? '0 : div_cnt + 1'b1;
      if (us_end) begin
        us_cnt <= ms_end ? '0 : us_cnt + 1'b1;
      end
      if (ms_end) begin
        ms_cnt <= hz_end ? '0 : ms_cnt + 1'b1;
      end
      tick_us_q   <= us_end;
      tick_ms_q   <= ms_end;
      tick_10hz_q <= hz_end;
      blink_q     <= blink_q ^ hz_end;
    end
  end

  assign ticks.tick_us   = tick_us_q;
  assign ticks.tick_ms   = tick_ms_q;
  assign ticks.tick_10hz = tick_10hz_q;
  assign ticks.blink     = blink_q;

  // Slower ticks stay aligned to the microsecond grid
  a_ms_on_us: assert property (@(posedge clk) disable iff (!rst_n)
    tick_ms_q |-> tick_us_q);

endmodule

`default_nettype wire

/* radio_capture.sv */
// Receiver channel decoder: measures one pulse input in microseconds and turns
// it into a clamped channel value. Falls back to DEFAULT when pulses stop.
`timescale 1ns/1ps
`default_nettype none
`include "avionics_config.svh"

module radio_capture #(
  parameter avionics_pkg::chan_val_t DEFAULT = '0
) (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    sig,
  tick_if.sink                    ticks,
  output avionics_pkg::chan_val_t value,
  output logic                    valid
);
  import avionics_pkg::*;

  // Without tick_us for this many clocks the timebase is considered stopped
  localparam int        STALL_CLKS = 4 * `AV_CLKS_PER_US;
  localparam int        STALL_W    = $clog2(STALL_CLKS + 1);
  localparam us_count_t PULSE_MIN  = us_count_t'(`AV_PULSE_MIN_US);
  localparam us_count_t TIMEOUT    = us_count_t'(`AV_RADIO_TIMEOUT_US);

  logic               sig_meta;
  logic               sig_sync;
  logic               sig_prev;
  logic               rise;
  logic               fall;
  us_count_t          high_us;
  us_count_t          gap_us;
  us_count_t          span;
  chan_val_t          conv;
  logic [STALL_W-1:0] stall_cnt;
  logic               stalled;
  logic               timed_out;

  assign rise      = sig_sync && !sig_prev;
  assign fall      = !sig_sync && sig_prev;
  assign stalled   = (stall_cnt == STALL_W'(STALL_CLKS));
  assign timed_out = (gap_us >= TIMEOUT);
  assign span      = high_us - PULSE_MIN;

  // Clamp the measured width into 0..1023
  always_comb begin
    if (high_us < PULSE_MIN) begin
      conv = '0;
    end else if (|span[$bits(us_count_t)-1:$bits(chan_val_t)]) begin
      conv = '1;
    end else begin
      conv = span[$bits(chan_val_t)-1:0];
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      sig_meta  <= 1'b0;
      sig_sync  <= 1'b0;
      sig_prev  <= 1'b0;
      high_us   <= '0;
      gap_us    <= '0;
      stall_cnt <= '0;
      value     <= DEFAULT;
      valid     <= 1'b0;
    end else begin
      sig_meta <= sig;
      sig_sync <= sig_meta;
      sig_prev <= sig_sync;

      if (rise) begin
        high_us <= '0;
      end else if (sig_sync && ticks.tick_us && high_us != '1) begin
        high_us <= high_us + 1'b1;
      end

      if (fall) begin
        gap_us <= '0;
      end else if (ticks.tick_us && !timed_out) begin
        gap_us <= gap_us + 1'b1;
      end

      if (ticks.tick_us) begin
        stall_cnt <= '0;
      end else if (!stalled) begin
        stall_cnt <= stall_cnt + 1'b1;
      end

      if (stalled) begin
        value <= DEFAULT;
        valid <= 1'b0;
      end else if (fall) begin
        value <= conv;
        valid <= 1'b1;
      end else if (timed_out) begin
        value <= DEFAULT;
        valid <= 1'b0;
      end
    end
  end

  a_default_when_invalid: assert property (@(posedge clk) disable iff (!rst_n)
    !valid |-> value == DEFAULT);

endmodule

`default_nettype wire

/* board_control.sv */
// Board controller: debounced power button stepping the board FSM, arm gesture
// detection, running timestamp and LED display. Selects the output commands.
`timescale 1ns/1ps
`default_nettype none
`include "avionics_config.svh"

module board_control (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     power_btn,
  tick_if.sink                     ticks,
  input  avionics_pkg::chan_val_t  thr_val,
  input  avionics_pkg::chan_val_t  elev_val,
  input  logic                     thr_valid,
  input  logic                     elev_valid,
  output logic                     run,
  output avionics_pkg::chan_val_t  esc_val,
  output avionics_pkg::servo_val_t servo_val,
  output logic                     enable,
  output logic [7:0]               led
);
  import avionics_pkg::*;

  localparam int DEB_W  = $clog2(`AV_DEBOUNCE_MS + 1);
  localparam int HOLD_W = $clog2(`AV_ARM_HOLD + 1);

  board_state_t      state;
  board_state_t      state_next;
  logic              btn_meta;
  logic              btn_sync;
  logic              btn_stable;
  logic [DEB_W-1:0]  deb_cnt;
  logic              btn_accept;
  logic              press;
  logic              gesture;
  logic              gesture_done;
  logic              armed;
  logic [HOLD_W-1:0] hold_cnt;
  logic [12:0]       timestamp;

  // New button level accepted after a full debounce window of tick_ms
  assign btn_accept = ticks.tick_ms && (btn_sync != btn_stable)
                      && (deb_cnt == DEB_W'(`AV_DEBOUNCE_MS));
  assign press      = btn_accept && btn_sync;

  // Timebase also runs while an idle press is being qualified
  assign run = (state != BOARD_IDLE) || (btn_sync != btn_stable);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      btn_meta   <= 1'b0;
      btn_sync   <= 1'b0;
      btn_stable <= 1'b0;
      deb_cnt    <= '0;
    end else begin
      btn_meta <= power_btn;
      btn_sync <= btn_meta;
      if (btn_sync == btn_stable) begin
        deb_cnt <= '0;
      end else if (btn_accept) begin
        btn_stable <= btn_sync;
        deb_cnt    <= '0;
      end else if (ticks.tick_ms) begin
        deb_cnt <= deb_cnt + 1'b1;
      end
    end
  end

  always_comb begin
    case (state)
      BOARD_IDLE:    state_next = BOARD_STARTUP;
      BOARD_STARTUP: state_next = BOARD_RUNNING;
      BOARD_RUNNING: state_next = BOARD_SHUTDOWN;
      default:       state_next = BOARD_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= BOARD_IDLE;
    end else if (press) begin
      state <= state_next;
    end
  end

  // Throttle low and elevator high, both channels live
  assign gesture = thr_valid && elev_valid
                   && (thr_val < chan_val_t'(`AV_ARM_THR_MAX))
                   && (elev_val >= chan_val_t'(`AV_ARM_ELEV_MIN));

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      hold_cnt     <= '0;
      gesture_done <= 1'b0;
      armed        <= 1'b0;
    end else if (state != BOARD_RUNNING) begin
      hold_cnt     <= '0;
      gesture_done <= 1'b0;
      armed        <= 1'b0;
    end else if (!gesture) begin
      hold_cnt     <= '0;
      gesture_done <= 1'b0;
    end else if (ticks.tick_10hz && !gesture_done) begin
      if (hold_cnt == HOLD_W'(`AV_ARM_HOLD - 1)) begin
        armed        <= !armed;
        gesture_done <= 1'b1;
        hold_cnt     <= '0;
      end else begin
        hold_cnt <= hold_cnt + 1'b1;
      end
    end
  end

  // Millisecond timestamp, restarts on every entry into running
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      timestamp <= '0;
    end else if (state != BOARD_RUNNING) begin
      timestamp <= '0;
    end else if (ticks.tick_ms) begin
      timestamp <= timestamp + 1'b1;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      led <= '0;
    end else begin
      case (state)
        BOARD_IDLE:    led <= '0;
        BOARD_RUNNING: led <= timestamp[12:5];
        default:       led <= {8{ticks.blink}};
      endcase
    end
  end

  assign esc_val   = thr_val;
  assign servo_val = elev_val[9:2];
  assign enable    = (state == BOARD_RUNNING) && armed;

  // Arming only happens after a full cycle inside running
  a_enable_in_running: assert property (@(posedge clk) disable iff (!rst_n)
    enable |-> (state == BOARD_RUNNING) && $past(state == BOARD_RUNNING));

endmodule

`default_nettype wire

/* pulse_output.sv */
// ESC and servo pulse generator. Emits one pulse per frame on each output,
// widths latched at frame start. Both outputs idle low while disabled.
`timescale 1ns/1ps
`default_nettype none
`include "avionics_config.svh"

module pulse_output (
  input  logic                     clk,
  input  logic                     rst_n,
  tick_if.sink                     ticks,
  input  logic                     enable,
  input  avionics_pkg::chan_val_t  esc_val,
  input  avionics_pkg::servo_val_t servo_val,
  output logic                     esc_sig,
  output logic                     servo_sig
);
  import avionics_pkg::*;

  localparam us_count_t PULSE_MIN = us_count_t'(`AV_PULSE_MIN_US);
  localparam us_count_t FRAME_END = us_count_t'(`AV_FRAME_US - 1);
  localparam us_count_t STEP      = us_count_t'(`AV_SERVO_STEP_US);

  us_count_t frame_us;
  us_count_t count_next;
  us_count_t esc_width;
  us_count_t servo_width;
  logic      in_frame;
  logic      frame_start;

  assign count_next  = frame_us + 1'b1;
  assign frame_start = !in_frame || (frame_us == FRAME_END);

  // Widths held for the whole frame
  always_ff @(posedge clk) begin
    if (enable && ticks.tick_us && frame_start) begin
      esc_width   <= PULSE_MIN + us_count_t'(esc_val);
      servo_width <= PULSE_MIN + us_count_t'(servo_val) * STEP;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      frame_us  <= '0;
      in_frame  <= 1'b0;
      esc_sig   <= 1'b0;
      servo_sig <= 1'b0;
    end else if (!enable) begin
      frame_us  <= '0;
      in_frame  <= 1'b0;
      esc_sig   <= 1'b0;
      servo_sig <= 1'b0;
    end else if (ticks.tick_us) begin
      if (frame_start) begin
        frame_us  <= '0;
        in_frame  <= 1'b1;
        esc_sig   <= 1'b1;
        servo_sig <= 1'b1;
      end else begin
        frame_us  <= count_next;
        esc_sig   <= (count_next < esc_width);
        servo_sig <= (count_next < servo_width);
      end
    end
  end

  a_quiet_when_disabled: assert property (@(posedge clk) disable iff (!rst_n)
    !enable |=> !esc_sig && !servo_sig);

endmodule

`default_nettype wire

/* avionics_top.sv */
// Flight-control core top level: timebase, throttle and elevator decoders,
// board controller and ESC/servo pulse outputs.
`timescale 1ns/1ps
`default_nettype none
`include "avionics_config.svh"

module avionics_top #(
  parameter int CLKS_PER_US = `AV_CLKS_PER_US
) (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       power_btn,
  input  logic       thr_sig,
  input  logic       elev_sig,
  output logic [7:0] led,
  output logic       esc_sig,
  output logic       servo_sig
);
  import avionics_pkg::*;

  tick_if ticks ();

  logic       run;
  chan_val_t  thr_val;
  chan_val_t  elev_val;
  logic       thr_valid;
  logic       elev_valid;
  chan_val_t  esc_val;
  servo_val_t servo_val;
  logic       enable;

  tick_gen #(
    .CLKS_PER_US(CLKS_PER_US)
  ) u_tick_gen (
    .clk   (clk),
    .rst_n (rst_n),
    .run   (run),
    .ticks (ticks.source)
  );

  // Throttle idles at zero when the link is lost
  radio_capture #(
    .DEFAULT(chan_val_t'(0))
  ) u_thr_capture (
    .clk   (clk),
    .rst_n (rst_n),
    .sig   (thr_sig),
    .ticks (ticks.sink),
    .value (thr_val),
    .valid (thr_valid)
  );

  // Elevator centres when the link is lost
  radio_capture #(
    .DEFAULT(chan_val_t'(512))
  ) u_elev_capture (
    .clk   (clk),
    .rst_n (rst_n),
    .sig   (elev_sig),
    .ticks (ticks.sink),
    .value (elev_val),
    .valid (elev_valid)
  );

  board_control u_board_control (
    .clk        (clk),
    .rst_n      (rst_n),
    .power_btn  (power_btn),
    .ticks      (ticks.sink),
    .thr_val    (thr_val),
    .elev_val   (elev_val),
    .thr_valid  (thr_valid),
    .elev_valid (elev_valid),
    .run        (run),
    .esc_val    (esc_val),
    .servo_val  (servo_val),
    .enable     (enable),
    .led        (led)
  );

  pulse_output u_pulse_output (
    .clk       (clk),
    .rst_n     (rst_n),
    .ticks     (ticks.sink),
    .enable    (enable),
    .esc_val   (esc_val),
    .servo_val (servo_val),
    .esc_sig   (esc_sig),
    .servo_sig (servo_sig)
  );

endmodule

`default_nettype wire

/* tb_avionics.sv */
// Testbench for the flight-control core top level.
// Drives button presses and receiver pulse frames, measures the ESC and servo
// pulses and checks them against widths derived from the decoding rules.
`timescale 1ns/1ps
`default_nettype none
`include "avionics_config.svh"

module tb_avionics;

  localparam int CLKS_PER_US = 2;
  localparam int MS_CYCLES   = CLKS_PER_US * 1000;
  localparam int FRAME_US    = `AV_FRAME_US;
  localparam int NUM_RANDOM  = 4;
  // Ten 10 Hz ticks plus the tick phase and one radio frame
  localparam int ARM_WAIT_US = 1_300_000;

  // Rough length of each test in ms
  localparam int TEST1_MS  = 25;
  localparam int TEST2_MS  = 120;
  localparam int TEST3_MS  = 20 + ARM_WAIT_US / 1000 + NUM_RANDOM * 100;
  localparam int TEST4_MS  = 200;
  localparam int TEST5_MS  = 150;
  localparam int RUN_LIMIT = (TEST1_MS + TEST2_MS + TEST3_MS + TEST4_MS + TEST5_MS)
                             * MS_CYCLES * 6 / 5;

  logic        clk = 1'b0;
  logic        rst_n;
  logic        power_btn;
  logic        thr_sig;
  logic        elev_sig;
  logic [7:0]  led;
  logic        esc_sig;
  logic        servo_sig;

  logic        radio_on;
  logic        quiet_expected;
  int          thr_width_us;
  int          elev_width_us;
  int          frames_sent;
  int          pass_count;
  int          fail_count;
  int          cycle_count;
  logic [31:0] lfsr;

  avionics_top #(
    .CLKS_PER_US(CLKS_PER_US)
  ) uut (
    .clk       (clk),
    .rst_n     (rst_n),
    .power_btn (power_btn),
    .thr_sig   (thr_sig),
    .elev_sig  (elev_sig),
    .led       (led),
    .esc_sig   (esc_sig),
    .servo_sig (servo_sig)
  );

  always #4 clk = ~clk;

  // Outputs must stay silent while the board is not running and armed
  quiet_check: assert property (@(posedge clk) disable iff (!rst_n)
    quiet_expected |-> !esc_sig && !servo_sig)
    else begin
      fail_count++;
      $display("Error at %0d ns: esc_sig,servo_sig expected 00, got %b%b",
               $time, esc_sig, servo_sig);
    end

  // Both pulses open together at frame start
  frame_check: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(esc_sig) |-> $rose(servo_sig))
    else begin
      fail_count++;
      $display("Frame start mismatch at %0d ns: esc_sig rose without servo_sig", $time);
    end

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count == RUN_LIMIT) begin
      $display("Timeout: run stopped after %0d cycles", cycle_count);
      $display("=== FAIL ===");
      $finish;
    end
  end

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic rand_bits(input int count, output int value);
    int i;
    value = 0;
    for (i = 0; i < count; i++) begin
      value = (value << 1) | int'(lfsr[31]);
      lfsr  = lfsr_next(lfsr);
    end
  endtask

  // Receiver width to channel value, clamped to 0..1023
  function automatic int clamp_chan(input int width_us);
    int v;
    v = width_us - `AV_PULSE_MIN_US;
    if (v < 0) begin
      v = 0;
    end
    if (v > 1023) begin
      v = 1023;
    end
    return v;
  endfunction

  function automatic int esc_width_for(input int chan);
    return `AV_PULSE_MIN_US + chan;
  endfunction

  // Servo keeps the upper 8 bits of the channel
  function automatic int servo_width_for(input int chan);
    return `AV_PULSE_MIN_US + `AV_SERVO_STEP_US * (chan >> 2);
  endfunction

  task automatic wait_ms(input int ms);
    repeat (ms * MS_CYCLES) @(posedge clk);
  endtask

  task automatic wait_frames(input int count);
    int target;
    target = frames_sent + count;
    while (frames_sent < target) begin
      @(posedge clk);
    end
  endtask

  // Hold the button, release it, then let the release settle
  task automatic press_button(input int hold_ms);
    @(posedge clk);
    #1 power_btn = 1'b1;
    wait_ms(hold_ms);
    #1 power_btn = 1'b0;
    wait_ms(5);
  endtask

  // One receiver frame, both channels start together
  task automatic send_frame(input int thr_w, input int elev_w);
    int t;
    @(posedge clk);
    #1;
    thr_sig  = 1'b1;
    elev_sig = 1'b1;
    for (t = 0; t < FRAME_US; t++) begin
      if (t == thr_w) begin
        thr_sig = 1'b0;
      end
      if (t == elev_w) begin
        elev_sig = 1'b0;
      end
      repeat (CLKS_PER_US) @(posedge clk);
      #1;
    end
    thr_sig  = 1'b0;
    elev_sig = 1'b0;
  endtask

  // Width in us of the next full pulse, -1 if none starts in time
  task automatic measure_pulse(input bit use_servo, input int limit_us, output int width_us);
    int waited;
    int high_cycles;
    waited      = 0;
    high_cycles = 0;
    width_us    = -1;
    @(negedge clk);
    while ((use_servo ? servo_sig : esc_sig) && waited < limit_us * CLKS_PER_US) begin
      @(negedge clk);
      waited++;
    end
    while (!(use_servo ? servo_sig : esc_sig) && waited < limit_us * CLKS_PER_US) begin
      @(negedge clk);
      waited++;
    end
    if (use_servo ? servo_sig : esc_sig) begin
      while (use_servo ? servo_sig : esc_sig) begin
        high_cycles++;
        @(negedge clk);
      end
      width_us = high_cycles / CLKS_PER_US;
    end
  endtask

  task automatic measure_outputs(input int limit_us, output int esc_w, output int srv_w);
    fork
      measure_pulse(1'b0, limit_us, esc_w);
      measure_pulse(1'b1, limit_us, srv_w);
    join
  endtask

  task automatic check_width(input string name, input int expected, input int actual);
    assert (actual >= 0)
    else begin
      fail_count++;
      $display("No pulse seen on %s by %0d ns", name, $time);
      return;
    end
    assert (actual >= expected - 1 && actual <= expected + 1) pass_count++;
    else begin
      fail_count++;
      $display("Error at %0d ns: %s expected %0d, got %0d", $time, name, expected, actual);
    end
  endtask

  task automatic expect_no_pulses(input int limit_us);
    int esc_w;
    int srv_w;
    measure_outputs(limit_us, esc_w, srv_w);
    assert (esc_w < 0 && srv_w < 0) pass_count++;
    else begin
      fail_count++;
      $display("Outputs pulsed when they should be silent, at %0d ns", $time);
    end
  endtask

  // all_equal selects the blink pattern check, otherwise led must stay 0
  task automatic scan_led(input int ms, input bit all_equal, input string what);
    int   i;
    int   bad_time;
    logic seen;
    logic [7:0] bad;
    seen     = 1'b0;
    bad      = '0;
    bad_time = 0;
    for (i = 0; i < ms * MS_CYCLES; i++) begin
      @(negedge clk);
      if (!seen && (all_equal ? !(led == 8'h00 || led == 8'hff) : (led != 8'h00))) begin
        seen     = 1'b1;
        bad      = led;
        bad_time = $time;
      end
    end
    assert (!seen) pass_count++;
    else begin
      fail_count++;
      $display("Error at %0d ns: led expected %s, got %h", bad_time, what, bad);
    end
  endtask

  task automatic report_test(input int num, input string name, input int fails_before);
    $display("Test %0d %s: %s", num, name, (fail_count == fails_before) ? "ok" : "errors");
  endtask

  initial begin : radio_gen
    forever begin
      if (radio_on) begin
        send_frame(thr_width_us, elev_width_us);
        frames_sent++;
      end else begin
        @(posedge clk);
      end
    end
  end

  initial begin : main_seq
    int esc_w;
    int srv_w;
    int r;
    int n;
    int fails_before;
    rst_n          = 1'b0;
    power_btn      = 1'b0;
    thr_sig        = 1'b0;
    elev_sig       = 1'b0;
    radio_on       = 1'b0;
    quiet_expected = 1'b1;
    thr_width_us   = 0;
    elev_width_us  = 0;
    frames_sent    = 0;
    pass_count     = 0;
    fail_count     = 0;
    cycle_count    = 0;
    lfsr           = 32'h4b81;
    repeat (5) @(posedge clk);
    #1 rst_n = 1'b1;

    fails_before = fail_count;
    fork
      scan_led(FRAME_US / 1000 + 1, 1'b0, "00");
      expect_no_pulses(FRAME_US + 1000);
    join
    report_test(1, "reset state", fails_before);

    fails_before = fail_count;
    // Glitch shorter than the debounce window
    press_button(1);
    scan_led(5, 1'b0, "00");
    press_button(5);
    scan_led(10, 1'b1, "all bits equal");
    press_button(5);
    @(negedge clk);
    assert (led == 8'h00) pass_count++;
    else begin
      fail_count++;
      $display("Error at %0d ns: led expected 00, got %h", $time, led);
    end
    wait_ms(40);
    @(negedge clk);
    assert (led != 8'h00) pass_count++;
    else begin
      fail_count++;
      $display("Error at %0d ns: led expected nonzero, got %h", $time, led);
    end
    press_button(5);
    scan_led(5, 1'b1, "all bits equal");
    press_button(5);
    scan_led(5, 1'b0, "00");
    report_test(2, "button and board states", fails_before);

    fails_before = fail_count;
    press_button(5);
    press_button(5);
    quiet_expected = 1'b0;
    // Throttle low and elevator high arms the motor
    thr_width_us   = 1010;
    elev_width_us  = 1982;
    radio_on       = 1'b1;
    measure_outputs(ARM_WAIT_US, esc_w, srv_w);
    check_width("esc_sig width", esc_width_for(clamp_chan(1010)), esc_w);
    check_width("servo_sig width", servo_width_for(clamp_chan(1982)), srv_w);
    for (n = 0; n < NUM_RANDOM; n++) begin
      rand_bits(10, r);
      thr_width_us = 1000 + r;
      // Elevator value kept at 4k+2 so a 1 us capture error cannot cross a step
      rand_bits(8, r);
      elev_width_us = 1002 + 4 * r;
      wait_frames(2);
      measure_outputs(2 * FRAME_US, esc_w, srv_w);
      check_width("esc_sig width", esc_width_for(clamp_chan(thr_width_us)), esc_w);
      check_width("servo_sig width", servo_width_for(clamp_chan(elev_width_us)), srv_w);
    end
    report_test(3, "arming and pulse widths", fails_before);

    fails_before  = fail_count;
    elev_width_us = 1502;
    thr_width_us  = 950;
    wait_frames(2);
    measure_outputs(2 * FRAME_US, esc_w, srv_w);
    check_width("esc_sig width", esc_width_for(clamp_chan(950)), esc_w);
    check_width("servo_sig width", servo_width_for(clamp_chan(1502)), srv_w);
    thr_width_us = 2100;
    wait_frames(2);
    measure_outputs(2 * FRAME_US, esc_w, srv_w);
    check_width("esc_sig width", esc_width_for(clamp_chan(2100)), esc_w);
    report_test(4, "throttle clamping", fails_before);

    fails_before = fail_count;
    radio_on     = 1'b0;
    wait_ms(50);
    // Lost link falls back to throttle 0 and elevator 512
    measure_outputs(2 * FRAME_US, esc_w, srv_w);
    check_width("esc_sig width", esc_width_for(0), esc_w);
    check_width("servo_sig width", servo_width_for(512), srv_w);
    press_button(5);
    quiet_expected = 1'b1;
    expect_no_pulses(FRAME_US + 2000);
    report_test(5, "radio timeout and shutdown", fails_before);

    $display("Checks: %0d passed, %0d failed", pass_count, fail_count);
    if (fail_count == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* verilog.f */
+incdir+.
avionics_pkg.sv
tick_if.sv
tick_gen.sv
radio_capture.sv
board_control.sv
pulse_output.sv
avionics_top.sv
tb_avionics.sv
